// ==== logic/cu_arbiter_pkg.sv ====
// Shared constants for the CU arbiter
// Word widths, CU-id field position, buffer depths and
// the vertex lane count used by the enable decode
package cu_arbiter_pkg;

	// Read command word, CU id in the top bits
	parameter int CMD_WIDTH = 32;

	// Memory read response word
	parameter int RESP_WIDTH = 32;

	// Top bit of the CU-id field in a response word
	parameter int CU_ID_MSB = 31;

	// Vertex job word from the host
	parameter int JOB_WIDTH = 32;

	// Done counts and totals
	parameter int COUNT_WIDTH = 32;

	// Buffer depths
	parameter int CMD_FIFO_DEPTH = 16;
	parameter int JOB_FIFO_DEPTH = 16;

	// Free slots left when almost-full rises
	parameter int ALFULL_MARGIN = 2;

	// Vertex lanes inside each graph CU
	parameter int VERTEX_CU_PER_CU = 4;

endpackage

// ==== logic/sync_fifo.sv ====
// Synchronous FIFO with a registered read port,
// occupancy count and an almost-full flag
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             out_valid,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
	localparam logic [CNT_W-1:0] AF_CNT = CNT_W'(DEPTH - cu_arbiter_pkg::ALFULL_MARGIN);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty  = (count == '0);
	assign full   = (count == FULL_CNT);
	assign alfull = (count >= AF_CNT);

	// Storage and read port
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= do_pop;
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/rr_grant.sv ====
// Round-robin arbiter, registered one-hot grant
// with a rotating priority pointer
`timescale 1ns/1ns

module rr_grant #(
	parameter int NUM_CU = 4
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic [NUM_CU-1:0] requests,
	output logic [NUM_CU-1:0] grant
);

	localparam int IDX_W = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;
	// Pointer starts on the last CU so CU 0 wins first
	localparam logic [IDX_W-1:0] START = IDX_W'(NUM_CU - 1);

	logic [IDX_W-1:0]  last;
	logic [IDX_W-1:0]  next_last;
	logic [NUM_CU-1:0] next_grant;
	logic              found;

	// Search begins just past the last winner
	always_comb begin
		int idx;
		next_grant = '0;
		next_last  = last;
		found      = 1'b0;
		for (int k = 1; k <= NUM_CU; k++) begin
			idx = (int'(last) + k) % NUM_CU;
			if (!found && requests[idx]) begin
				found           = 1'b1;
				next_grant[idx] = 1'b1;
				next_last       = IDX_W'(idx);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			grant <= '0;
			last  <= START;
		end else if (enabled && found) begin
			grant <= next_grant;
			last  <= next_last;
		end else begin
			grant <= '0;
		end
	end

endmodule

// ==== logic/cmd_gather.sv ====
// Read command gathering: CU grant, command buffer
// and the request/grant exchange with the memory port
`timescale 1ns/1ns

module cmd_gather #(
	parameter int NUM_CU = 4
) (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         enabled,
	input  logic [NUM_CU-1:0]                            cu_cmd_request,
	input  logic [NUM_CU-1:0]                            cu_cmd_valid,
	input  logic [NUM_CU*cu_arbiter_pkg::CMD_WIDTH-1:0] cu_cmd_word,
	output logic [NUM_CU-1:0]                            cu_cmd_grant,
	input  logic                                         mem_alfull,
	input  logic                                         mem_cmd_grant,
	output logic                                         mem_cmd_request,
	output logic                                         mem_cmd_valid,
	output logic [cu_arbiter_pkg::CMD_WIDTH-1:0]        mem_cmd_word
);

	localparam int CW = cu_arbiter_pkg::CMD_WIDTH;

	logic [CW-1:0] push_word;
	logic          push;
	logic          grant_en;
	logic          cmd_pop;
	logic          fifo_empty;
	logic          fifo_alfull;

	//////////////////////////////////////////////////////////////////////
	// CU side
	//////////////////////////////////////////////////////////////////////

	// No new CU grants while the buffer is nearly full
	assign grant_en = enabled && !fifo_alfull;

	rr_grant #(
		.NUM_CU(NUM_CU)
	) u_cmd_grant (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (grant_en),
		.requests(cu_cmd_request),
		.grant   (cu_cmd_grant)
	);

	// At most one CU answers per cycle
	always_comb begin
		push_word = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (cu_cmd_valid[i]) begin
				push_word = cu_cmd_word[i*CW +: CW];
			end
		end
	end

	assign push = |cu_cmd_valid;

	sync_fifo #(
		.WIDTH(CW),
		.DEPTH(cu_arbiter_pkg::CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push),
		.data_in  (push_word),
		.pop      (cmd_pop),
		.data_out (mem_cmd_word),
		.out_valid(mem_cmd_valid),
		.empty    (fifo_empty),
		.full     (),
		.alfull   (fifo_alfull)
	);

	//////////////////////////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cmd_pop         <= 1'b0;
			mem_cmd_request <= 1'b0;
		end else begin
			cmd_pop <= enabled && mem_cmd_grant;
			// Request holds its value while disabled
			if (enabled) begin
				mem_cmd_request <= !fifo_empty && !mem_alfull;
			end
		end
	end

endmodule

// ==== logic/resp_steer.sv ====
// Response steering: decodes the CU-id field of a read
// response into a one-hot valid, one register stage
`timescale 1ns/1ns

module resp_steer #(
	parameter int NUM_CU = 4
) (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 resp_valid,
	input  logic [cu_arbiter_pkg::RESP_WIDTH-1:0] resp_word,
	output logic [NUM_CU-1:0]                    cu_resp_valid,
	output logic [cu_arbiter_pkg::RESP_WIDTH-1:0] cu_resp_word
);

	localparam int ID_W = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;

	logic [ID_W-1:0]   cu_id;
	logic [NUM_CU-1:0] id_hit;

	// Id field sits at the top of the word
	assign cu_id = resp_word[cu_arbiter_pkg::CU_ID_MSB -: ID_W];

	for (genvar i = 0; i < NUM_CU; i++) begin : g_decode
		assign id_hit[i] = resp_valid && (cu_id == ID_W'(i));
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cu_resp_valid <= '0;
		end else begin
			cu_resp_valid <= id_hit;
		end
	end

	// Word is shared by all CUs
	always_ff @(posedge clock) begin
		cu_resp_word <= resp_word;
	end

endmodule

// ==== logic/job_dispatch.sv ====
// Vertex job dispatch: job buffer, one staging register
// and round-robin delivery to CUs asking for work
`timescale 1ns/1ns

module job_dispatch #(
	parameter int NUM_CU = 4
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  logic                                job_valid,
	input  logic [cu_arbiter_pkg::JOB_WIDTH-1:0] job_word,
	output logic                                mem_job_request,
	input  logic [NUM_CU-1:0]                   cu_job_request,
	output logic [NUM_CU-1:0]                   cu_job_valid,
	output logic [cu_arbiter_pkg::JOB_WIDTH-1:0] cu_job_word
);

	localparam int JW = cu_arbiter_pkg::JOB_WIDTH;

	logic          job_empty;
	logic          job_alfull;
	logic          job_pop;
	logic          fifo_valid;
	logic [JW-1:0] fifo_word;
	logic          stage_valid;
	logic          deliver;
	logic          grant_en;

	sync_fifo #(
		.WIDTH(JW),
		.DEPTH(cu_arbiter_pkg::JOB_FIFO_DEPTH)
	) u_job_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (job_valid),
		.data_in  (job_word),
		.pop      (job_pop),
		.data_out (fifo_word),
		.out_valid(fifo_valid),
		.empty    (job_empty),
		.full     (),
		.alfull   (job_alfull)
	);

	//////////////////////////////////////////////////////////////////////
	// Staging
	//////////////////////////////////////////////////////////////////////

	assign deliver = |cu_job_valid;

	// Next pop once the stage is free or being handed out
	assign job_pop = !job_empty && !fifo_valid && (!stage_valid || deliver);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			stage_valid     <= 1'b0;
			mem_job_request <= 1'b0;
		end else begin
			mem_job_request <= !job_alfull;
			if (fifo_valid) begin
				stage_valid <= 1'b1;
			end else if (deliver) begin
				stage_valid <= 1'b0;
			end
		end
	end

	// Staged word stays on the bus through the delivery cycle
	always_ff @(posedge clock) begin
		if (fifo_valid) begin
			cu_job_word <= fifo_word;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Delivery
	//////////////////////////////////////////////////////////////////////

	// One grant per staged job
	assign grant_en = enabled && stage_valid && !deliver;

	rr_grant #(
		.NUM_CU(NUM_CU)
	) u_job_grant (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (grant_en),
		.requests(cu_job_request),
		.grant   (cu_job_valid)
	);

endmodule

// ==== logic/done_sum.sv ====
// Done-count reduction: two-stage adder tree
// for vertex and edge counts of up to four CUs
`timescale 1ns/1ns

module done_sum #(
	parameter int NUM_CU = 4
) (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         enabled,
	input  logic [NUM_CU*cu_arbiter_pkg::COUNT_WIDTH-1:0] cu_vertex_done,
	input  logic [NUM_CU*cu_arbiter_pkg::COUNT_WIDTH-1:0] cu_edge_done,
	output logic [cu_arbiter_pkg::COUNT_WIDTH-1:0]        vertex_done_total,
	output logic [cu_arbiter_pkg::COUNT_WIDTH-1:0]        edge_done_total
);

	localparam int CW = cu_arbiter_pkg::COUNT_WIDTH;

	logic [CW-1:0] v_lane [4];
	logic [CW-1:0] e_lane [4];
	logic [CW-1:0] v_pair [2];
	logic [CW-1:0] e_pair [2];

	// Unused lanes read as zero
	for (genvar i = 0; i < 4; i++) begin : g_lane
		if (i < NUM_CU) begin : g_used
			assign v_lane[i] = cu_vertex_done[i*CW +: CW];
			assign e_lane[i] = cu_edge_done[i*CW +: CW];
		end else begin : g_pad
			assign v_lane[i] = '0;
			assign e_lane[i] = '0;
		end
	end

	// Pair sums, then the total; both wrap and hold while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			v_pair            <= '{default: '0};
			e_pair            <= '{default: '0};
			vertex_done_total <= '0;
			edge_done_total   <= '0;
		end else if (enabled) begin
			v_pair[0]         <= v_lane[0] + v_lane[1];
			v_pair[1]         <= v_lane[2] + v_lane[3];
			e_pair[0]         <= e_lane[0] + e_lane[1];
			e_pair[1]         <= e_lane[2] + e_lane[3];
			vertex_done_total <= v_pair[0] + v_pair[1];
			edge_done_total   <= e_pair[0] + e_pair[1];
		end
	end

endmodule

// ==== logic/cu_arbiter_top.sv ====
// CU arbiter top: input registers, configure latch,
// CU enable decode, response output register and the
// command, response, job and done-count blocks
`timescale 1ns/1ns

module cu_arbiter_top #(
	parameter int NUM_CU = 4
) (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         enabled_in,
	input  logic [63:0]                                  configure,
	output logic [NUM_CU-1:0]                            cu_enable,
	input  logic                                         resp_valid,
	input  logic [cu_arbiter_pkg::RESP_WIDTH-1:0]         resp_word,
	output logic [NUM_CU-1:0]                            cu_resp_valid,
	output logic [cu_arbiter_pkg::RESP_WIDTH-1:0]         cu_resp_word,
	input  logic [NUM_CU-1:0]                            cu_cmd_request,
	input  logic [NUM_CU-1:0]                            cu_cmd_valid,
	input  logic [NUM_CU*cu_arbiter_pkg::CMD_WIDTH-1:0]   cu_cmd_word,
	output logic [NUM_CU-1:0]                            cu_cmd_grant,
	input  logic                                         mem_alfull,
	input  logic                                         mem_cmd_grant,
	output logic                                         mem_cmd_request,
	output logic                                         mem_cmd_valid,
	output logic [cu_arbiter_pkg::CMD_WIDTH-1:0]          mem_cmd_word,
	input  logic                                         job_valid,
	input  logic [cu_arbiter_pkg::JOB_WIDTH-1:0]          job_word,
	output logic                                         mem_job_request,
	input  logic [NUM_CU-1:0]                            cu_job_request,
	output logic [NUM_CU-1:0]                            cu_job_valid,
	output logic [cu_arbiter_pkg::JOB_WIDTH-1:0]          cu_job_word,
	input  logic [NUM_CU*cu_arbiter_pkg::COUNT_WIDTH-1:0] cu_vertex_done,
	input  logic [NUM_CU*cu_arbiter_pkg::COUNT_WIDTH-1:0] cu_edge_done,
	output logic [cu_arbiter_pkg::COUNT_WIDTH-1:0]        vertex_done_total,
	output logic [cu_arbiter_pkg::COUNT_WIDTH-1:0]        edge_done_total
);

	localparam int RW   = cu_arbiter_pkg::RESP_WIDTH;
	localparam int CMDW = cu_arbiter_pkg::CMD_WIDTH;
	localparam int JW   = cu_arbiter_pkg::JOB_WIDTH;
	localparam int CNTW = cu_arbiter_pkg::COUNT_WIDTH;

	logic                     enabled;
	logic [63:0]              configure_q;
	logic [31:0]              cfg_latched;
	logic [NUM_CU-1:0]        enable_dec;
	logic                     resp_valid_q;
	logic [RW-1:0]            resp_word_q;
	logic [NUM_CU-1:0]        steer_valid;
	logic [RW-1:0]            steer_word;
	logic [NUM_CU-1:0]        cu_cmd_request_q;
	logic [NUM_CU-1:0]        cu_cmd_valid_q;
	logic [NUM_CU*CMDW-1:0]   cu_cmd_word_q;
	logic                     mem_alfull_q;
	logic                     mem_cmd_grant_q;
	logic                     job_valid_q;
	logic [JW-1:0]            job_word_q;
	logic [NUM_CU-1:0]        cu_job_request_q;
	logic [NUM_CU*CNTW-1:0]   vertex_done_q;
	logic [NUM_CU*CNTW-1:0]   edge_done_q;

	//////////////////////////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled          <= 1'b0;
			configure_q      <= '0;
			resp_valid_q     <= 1'b0;
			cu_cmd_request_q <= '0;
			cu_cmd_valid_q   <= '0;
			mem_alfull_q     <= 1'b0;
			mem_cmd_grant_q  <= 1'b0;
			job_valid_q      <= 1'b0;
			cu_job_request_q <= '0;
			vertex_done_q    <= '0;
			edge_done_q      <= '0;
		end else begin
			enabled          <= enabled_in;
			configure_q      <= configure;
			resp_valid_q     <= resp_valid;
			cu_cmd_request_q <= cu_cmd_request;
			cu_cmd_valid_q   <= cu_cmd_valid;
			mem_alfull_q     <= mem_alfull;
			mem_cmd_grant_q  <= mem_cmd_grant;
			job_valid_q      <= job_valid;
			cu_job_request_q <= cu_job_request;
			vertex_done_q    <= cu_vertex_done;
			edge_done_q      <= cu_edge_done;
		end
	end

	// Payloads
	always_ff @(posedge clock) begin
		resp_word_q   <= resp_word;
		cu_cmd_word_q <= cu_cmd_word;
		job_word_q    <= job_word;
	end

	//////////////////////////////////////////////////////////////////////
	// Configure latch and CU enables
	//////////////////////////////////////////////////////////////////////

	// A zero word keeps the previous setting
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cfg_latched <= '0;
		end else if (|configure_q) begin
			cfg_latched <= configure_q[31:0];
		end
	end

	// CU i is on while its first vertex lane is below the lane count
	for (genvar i = 0; i < NUM_CU; i++) begin : g_enable
		assign enable_dec[i] = (32'(i * cu_arbiter_pkg::VERTEX_CU_PER_CU) < cfg_latched);
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cu_enable     <= '0;
			cu_resp_valid <= '0;
		end else begin
			cu_enable     <= enable_dec;
			cu_resp_valid <= steer_valid;
		end
	end

	always_ff @(posedge clock) begin
		cu_resp_word <= steer_word;
	end

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	resp_steer #(
		.NUM_CU(NUM_CU)
	) u_resp_steer (
		.clock        (clock),
		.rstn         (rstn),
		.resp_valid   (resp_valid_q),
		.resp_word    (resp_word_q),
		.cu_resp_valid(steer_valid),
		.cu_resp_word (steer_word)
	);

	cmd_gather #(
		.NUM_CU(NUM_CU)
	) u_cmd_gather (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.cu_cmd_request (cu_cmd_request_q),
		.cu_cmd_valid   (cu_cmd_valid_q),
		.cu_cmd_word    (cu_cmd_word_q),
		.cu_cmd_grant   (cu_cmd_grant),
		.mem_alfull     (mem_alfull_q),
		.mem_cmd_grant  (mem_cmd_grant_q),
		.mem_cmd_request(mem_cmd_request),
		.mem_cmd_valid  (mem_cmd_valid),
		.mem_cmd_word   (mem_cmd_word)
	);

	job_dispatch #(
		.NUM_CU(NUM_CU)
	) u_job_dispatch (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.job_valid      (job_valid_q),
		.job_word       (job_word_q),
		.mem_job_request(mem_job_request),
		.cu_job_request (cu_job_request_q),
		.cu_job_valid   (cu_job_valid),
		.cu_job_word    (cu_job_word)
	);

	done_sum #(
		.NUM_CU(NUM_CU)
	) u_done_sum (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.cu_vertex_done   (vertex_done_q),
		.cu_edge_done     (edge_done_q),
		.vertex_done_total(vertex_done_total),
		.edge_done_total  (edge_done_total)
	);

endmodule

// ==== verif/tb_cu_arbiter.sv ====
// Testbench for the CU arbiter top level
// Clock and reset, vector file reader, CU, host and memory models,
// value checks and a watchdog
`timescale 1ns/1ns

module tb_cu_arbiter;

	localparam int NUM_CU        = 4;
	localparam int CLK_PERIOD    = 20;
	localparam int VEC_WORDS     = 512;
	localparam int CYCLES_PER_OP = 200;

	logic                     clock;
	logic                     rstn;
	logic                     enabled_in;
	logic [63:0]              configure;
	logic [NUM_CU-1:0]        cu_enable;
	logic                     resp_valid;
	logic [31:0]              resp_word;
	logic [NUM_CU-1:0]        cu_resp_valid;
	logic [31:0]              cu_resp_word;
	logic [NUM_CU-1:0]        cu_cmd_request;
	logic [NUM_CU-1:0]        cu_cmd_valid;
	logic [NUM_CU*32-1:0]     cu_cmd_word;
	logic [NUM_CU-1:0]        cu_cmd_grant;
	logic                     mem_alfull;
	logic                     mem_cmd_grant;
	logic                     mem_cmd_request;
	logic                     mem_cmd_valid;
	logic [31:0]              mem_cmd_word;
	logic                     job_valid;
	logic [31:0]              job_word;
	logic                     mem_job_request;
	logic [NUM_CU-1:0]        cu_job_request;
	logic [NUM_CU-1:0]        cu_job_valid;
	logic [31:0]              cu_job_word;
	logic [NUM_CU*32-1:0]     cu_vertex_done;
	logic [NUM_CU*32-1:0]     cu_edge_done;
	logic [31:0]              vertex_done_total;
	logic [31:0]              edge_done_total;

	// Vector words, CU command queues and expected outputs
	logic [31:0]       vec_mem [VEC_WORDS];
	logic [31:0]       cu_q [NUM_CU][$];
	logic [31:0]       exp_cmd [NUM_CU][$];
	logic [31:0]       host_q [$];
	logic [31:0]       exp_job [$];
	int                grants_open;
	logic [NUM_CU-1:0] job_req_seen;

	cu_arbiter_top #(
		.NUM_CU(NUM_CU)
	) u_dut (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.configure        (configure),
		.cu_enable        (cu_enable),
		.resp_valid       (resp_valid),
		.resp_word        (resp_word),
		.cu_resp_valid    (cu_resp_valid),
		.cu_resp_word     (cu_resp_word),
		.cu_cmd_request   (cu_cmd_request),
		.cu_cmd_valid     (cu_cmd_valid),
		.cu_cmd_word      (cu_cmd_word),
		.cu_cmd_grant     (cu_cmd_grant),
		.mem_alfull       (mem_alfull),
		.mem_cmd_grant    (mem_cmd_grant),
		.mem_cmd_request  (mem_cmd_request),
		.mem_cmd_valid    (mem_cmd_valid),
		.mem_cmd_word     (mem_cmd_word),
		.job_valid        (job_valid),
		.job_word         (job_word),
		.mem_job_request  (mem_job_request),
		.cu_job_request   (cu_job_request),
		.cu_job_valid     (cu_job_valid),
		.cu_job_word      (cu_job_word),
		.cu_vertex_done   (cu_vertex_done),
		.cu_edge_done     (cu_edge_done),
		.vertex_done_total(vertex_done_total),
		.edge_done_total  (edge_done_total)
	);

	initial clock = 1'b0;
	always #(CLK_PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
		if (got !== want) begin
			$display("Fail at %0t ns: %s (got %0h, expected %0h)", $time, what, got, want);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	// Words per operation, opcode included
	function automatic int op_length(input logic [31:0] op);
		case (op)
			32'd1:   return 4;
			32'd2:   return 2;
			32'd3:   return 2;
			32'd4:   return 2;
			32'd5:   return 11;
			default: return 0;
		endcase
	endfunction

	function automatic int count_ops();
		int idx;
		int n;
		int len;
		idx = 0;
		n = 0;
		while (idx < VEC_WORDS && vec_mem[idx] != 32'd0) begin
			len = op_length(vec_mem[idx]);
			if (len == 0) begin
				return -1;
			end
			n++;
			idx += len;
		end
		return n;
	endfunction

	function automatic bit all_drained();
		bit done;
		done = (host_q.size() == 0) && (exp_job.size() == 0);
		for (int i = 0; i < NUM_CU; i++) begin
			if (cu_q[i].size() != 0 || exp_cmd[i].size() != 0) begin
				done = 1'b0;
			end
		end
		return done;
	endfunction

	task automatic watchdog(input int n_ops);
		#(longint'(n_ops) * CYCLES_PER_OP * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", n_ops * CYCLES_PER_OP);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Models
	//////////////////////////////////////////////////////////////////////

	// Each CU answers a grant with its next command for one cycle
	task automatic model_cu_commands();
		forever begin
			next_cycle();
			check(64'($countones(cu_cmd_grant) <= 1), 64'd1, "command grant not one-hot");
			cu_cmd_valid = '0;
			for (int i = 0; i < NUM_CU; i++) begin
				if (cu_cmd_grant[i] && cu_q[i].size() != 0) begin
					cu_cmd_valid[i] = 1'b1;
					cu_cmd_word[i*32 +: 32] = cu_q[i].pop_front();
				end
			end
			for (int i = 0; i < NUM_CU; i++) begin
				cu_cmd_request[i] = (cu_q[i].size() != 0);
			end
		end
	endtask

	// Random grants and almost-full bursts on the memory port
	task automatic model_memory();
		int alfull_left;
		int alfull_age;
		int cu;
		alfull_left = 0;
		alfull_age = 0;
		forever begin
			next_cycle();
			if (mem_cmd_valid) begin
				check(64'(grants_open > 0), 64'd1, "memory command without an open grant");
				grants_open--;
				cu = int'(mem_cmd_word[31:30]);
				check(64'(exp_cmd[cu].size() != 0), 64'd1, "unexpected memory command");
				check(64'(mem_cmd_word), 64'(exp_cmd[cu].pop_front()), "memory command word");
			end
			// Request must be gone 2 clocks into an almost-full burst
			alfull_age = mem_alfull ? alfull_age + 1 : 0;
			if (alfull_age >= 2) begin
				check(64'(mem_cmd_request), 64'd0, "memory request while almost full");
			end
			if (mem_alfull) begin
				if (alfull_left == 0) begin
					mem_alfull = 1'b0;
				end else begin
					alfull_left--;
				end
			end else if (($urandom % 16) == 0) begin
				mem_alfull = 1'b1;
				alfull_left = 2 + int'($urandom % 6);
			end
			mem_cmd_grant = mem_cmd_request && !mem_alfull && (($urandom % 3) != 0);
			if (mem_cmd_grant) begin
				grants_open++;
			end
		end
	endtask

	// Host pushes jobs only while the DUT asks for them
	task automatic model_host();
		forever begin
			next_cycle();
			job_valid = 1'b0;
			if (mem_job_request && host_q.size() != 0) begin
				job_valid = 1'b1;
				job_word = host_q.pop_front();
				exp_job.push_back(job_word);
			end
		end
	endtask

	// Job requests change at random; a delivery is matched to the
	// request the DUT registered two cycles before
	task automatic model_cu_jobs();
		forever begin
			next_cycle();
			if (cu_job_valid != '0) begin
				check(64'($countones(cu_job_valid)), 64'd1, "job delivery not one-hot");
				check(64'((cu_job_valid & job_req_seen) != '0), 64'd1, "job to an idle CU");
				check(64'(exp_job.size() != 0), 64'd1, "unexpected job delivery");
				check(64'(cu_job_word), 64'(exp_job.pop_front()), "job word");
			end
			job_req_seen = cu_job_request;
			cu_job_request = NUM_CU'($urandom);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          n_ops;
		int          idx;
		logic [31:0] op;
		logic [31:0] w;
		rstn = 1'b0;
		enabled_in = 1'b0;
		configure = '0;
		resp_valid = 1'b0;
		resp_word = '0;
		cu_cmd_request = '0;
		cu_cmd_valid = '0;
		cu_cmd_word = '0;
		mem_alfull = 1'b0;
		mem_cmd_grant = 1'b0;
		job_valid = 1'b0;
		job_word = '0;
		cu_job_request = '0;
		cu_vertex_done = '0;
		cu_edge_done = '0;
		grants_open = 0;
		job_req_seen = '0;
		void'($urandom(32'h3991));

		$readmemh("verif/cu_arbiter_vectors.txt", vec_mem);
		n_ops = count_ops();
		if (n_ops <= 0) begin
			$display("The vector file is missing, empty or holds an unknown opcode");
			$display("TEST FAILED");
			$fatal(1, "Bad vector file");
		end
		fork
			watchdog(n_ops);
		join_none

		repeat (10) @(posedge clock);
		#2;
		check(64'(cu_enable | cu_resp_valid | cu_cmd_grant | cu_job_valid), 64'd0, "reset state");
		check(64'({mem_cmd_request, mem_cmd_valid, mem_job_request}), 64'd0, "reset state");
		check({vertex_done_total, edge_done_total}, 64'd0, "totals after reset");
		rstn = 1'b1;
		enabled_in = 1'b1;
		next_cycle();
		fork
			model_cu_commands();
			model_memory();
			model_host();
			model_cu_jobs();
		join_none

		idx = 0;
		op = vec_mem[0];
		while (op != 32'd0) begin
			case (op)
				32'd1: begin
					configure = {vec_mem[idx+1], vec_mem[idx+2]};
					next_cycle();
					configure = '0;
					repeat (2) next_cycle();
					check(64'(cu_enable), 64'(vec_mem[idx+3]), "CU enables after configure");
				end
				32'd2: begin
					w = vec_mem[idx+1];
					resp_word = w;
					resp_valid = 1'b1;
					next_cycle();
					resp_valid = 1'b0;
					check(64'(cu_resp_valid), 64'd0, "response one clock after input");
					next_cycle();
					check(64'(cu_resp_valid), 64'd0, "response two clocks after input");
					next_cycle();
					check(64'(cu_resp_valid), 64'd1 << w[31:30], "response steering");
					check(64'(cu_resp_word), 64'(w), "response word");
					next_cycle();
					check(64'(cu_resp_valid), 64'd0, "response pulse length");
				end
				32'd3: begin
					w = vec_mem[idx+1];
					cu_q[w[31:30]].push_back(w);
					exp_cmd[w[31:30]].push_back(w);
					next_cycle();
				end
				32'd4: begin
					host_q.push_back(vec_mem[idx+1]);
					next_cycle();
				end
				default: begin
					for (int i = 0; i < NUM_CU; i++) begin
						cu_vertex_done[i*32 +: 32] = vec_mem[idx+1+i];
						cu_edge_done[i*32 +: 32] = vec_mem[idx+5+i];
					end
					repeat (3) next_cycle();
					check(64'(vertex_done_total), 64'(vec_mem[idx+9]), "vertex done total");
					check(64'(edge_done_total), 64'(vec_mem[idx+10]), "edge done total");
				end
			endcase
			idx += op_length(op);
			op = vec_mem[idx];
		end

		// Every command and job has to come out before the end
		while (!all_drained()) begin
			next_cycle();
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== verif/cu_arbiter_vectors.txt ====
// Hex words: opcode, then operands. 1 cfg_hi cfg_lo enable_mask | 2 resp_word | 3 cmd_word
// 4 job_word | 5 vtx0..vtx3 edge0..edge3 vtx_total edge_total | 0 end of run
1 00000000 0000000a 00000007
1 00000000 00000000 00000007
1 00000000 00000003 00000001
1 00000001 00000000 00000000
1 00000000 00000010 0000000f
3 00000010
3 40000020
3 00000011
3 c0000040
3 80000030
3 c0000041
3 00000012
3 40000021
3 c0000042
2 0000abcd
2 80001111
2 c0ffee01
2 4badf00d
4 10000001
4 10000002
4 10000003
4 10000004
4 10000005
5 00000001 00000002 00000003 00000004 00000010 00000020 00000030 00000040 0000000a 000000a0
5 ffffffff 00000002 80000000 80000000 12345678 11111111 00000000 fedcba98 00000001 22222221
0

// ==== tb.f ====
logic/cu_arbiter_pkg.sv
logic/sync_fifo.sv
logic/rr_grant.sv
logic/cmd_gather.sv
logic/resp_steer.sv
logic/job_dispatch.sv
logic/done_sum.sv
logic/cu_arbiter_top.sv
verif/tb_cu_arbiter.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_cu_arbiter
RTL_TOP    := cu_arbiter_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --top-module $(RTL_TOP)
RTL_SRCS   := $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
